//--- hw/fftPkg.sv
/*
 * FFT datapath definitions
 * Point count, stage count, fixed-point formats and the vector types
 * shared by the sample window, the butterfly engine and the bench
 */

`default_nettype none

package fftPkg;

	// Transform size
	localparam int pointCount = 8;
	localparam int stageCount = 3;

	// Input and datapath formats
	localparam int sampleWidth = 12;
	localparam int fracBits = 8;
	localparam int dataWidth = 24;

	// Butterflies per stage and the counter widths that walk them
	localparam int butterflyCount = pointCount / 2;
	localparam int stageBits = $clog2(stageCount);
	localparam int butterflyBits = $clog2(butterflyCount);

	// Raw signed audio sample
	typedef logic signed [sampleWidth-1:0] sample_t;

	// Datapath word, fracBits below the binary point
	typedef logic signed [dataWidth-1:0] data_t;

	// Twiddle factor, one sign bit plus fracBits fraction
	typedef logic signed [fracBits:0] twiddle_t;

	// Index of a point in the frame buffer
	typedef logic [stageCount-1:0] pointIndex_t;

	// Index into the twiddle tables
	typedef logic [stageCount-2:0] twiddleIndex_t;

	// Engine counters
	typedef logic [stageBits-1:0] stageIndex_t;
	typedef logic [butterflyBits-1:0] butterflyIndex_t;

	// Engine sequencing
	typedef enum logic [1:0] {
		idle,
		load,
		compute,
		publish
	} engineState_t;

endpackage

`default_nettype wire

//--- hw/fftTablesPkg.sv
/*
 * Twiddle constants
 * Cosine and negated sine of 2*pi*k/N in the twiddle fixed-point format,
 * one entry per twiddle number k
 */

`default_nettype none

package fftTablesPkg;

	import fftPkg::*;

	// Real part, round(256 * cos(2*pi*k/8))
	// Unity is one code past the signed range, so k = 0 holds the top code
	localparam twiddle_t twiddleReal [pointCount/2] = '{
		twiddle_t'(255),
		twiddle_t'(181),
		twiddle_t'(0),
		twiddle_t'(-181)
	};

	// Imaginary part, -round(256 * sin(2*pi*k/8))
	// Negative unity at k = 2 fits exactly
	localparam twiddle_t twiddleImag [pointCount/2] = '{
		twiddle_t'(0),
		twiddle_t'(-181),
		twiddle_t'(-256),
		twiddle_t'(-181)
	};

endpackage

`default_nettype wire

//--- hw/sampleWindow.sv
/*
 * Sliding sample window
 * Shifts in one sample per sampleValid, flags a pending frame for the
 * engine and presents the window bit-reversed and scaled to data_t
 */

`timescale 1ns/1ps
`default_nettype none

module sampleWindow import fftPkg::*; (
	input logic advanceSignal,
	input logic reset,

	// Sample input
	input sample_t sample,
	input logic sampleValid,

	// Engine handshake
	input logic frameTaken,
	output logic framePending,

	// Reordered frame
	output data_t frame [pointCount]
);

	// Entry 0 is the newest sample
	sample_t window [pointCount];

	// Mirror the index bits
	function automatic pointIndex_t bitReverse(input pointIndex_t index);
		pointIndex_t reversed;
		for (int k = 0; k < stageCount; k++) begin
			reversed[k] = index[stageCount-1-k];
		end
		return reversed;
	endfunction

	// Window shift and pending flag
	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			window <= '{default: '0};
			framePending <= 1'b0;
		end else begin
			if (sampleValid) begin
				window[0] <= sample;
				for (int i = 1; i < pointCount; i++) begin
					window[i] <= window[i-1];
				end
			end
			// A new sample wins over the engine taking the old frame
			if (sampleValid) begin
				framePending <= 1'b1;
			end else if (frameTaken) begin
				framePending <= 1'b0;
			end
		end
	end

	// Bit-reversed load order for the in-place engine
	always_comb begin
		for (int j = 0; j < pointCount; j++) begin
			// Sign extend, then move the integer up above the fraction
			frame[j] = data_t'(window[bitReverse(pointIndex_t'(j))]) <<< fracBits;
		end
	end

endmodule

`default_nettype wire

//--- hw/butterflyUnit.sv
/*
 * Radix-2 complex butterfly
 * upper = a + w*b, lower = a - w*b, purely combinational, results
 * wrap at the datapath width
 */

`timescale 1ns/1ps
`default_nettype none

module butterflyUnit import fftPkg::*; (
	// Operands
	input data_t aReal,
	input data_t aImag,
	input data_t bReal,
	input data_t bImag,

	// Twiddle
	input twiddle_t wReal,
	input twiddle_t wImag,

	// Results
	output data_t upperReal,
	output data_t upperImag,
	output data_t lowerReal,
	output data_t lowerImag
);

	data_t wRealWide;
	data_t wImagWide;
	data_t bRealScaled;
	data_t bImagScaled;
	data_t productReal;
	data_t productImag;

	always_comb begin
		// Twiddle sign-extended to the datapath width
		wRealWide = data_t'(wReal);
		wImagWide = data_t'(wImag);

		// Drop b's fraction first so the product lands back in data_t format
		bRealScaled = bReal >>> fracBits;
		bImagScaled = bImag >>> fracBits;

		// Complex multiply, products truncated to dataWidth
		productReal = (wRealWide * bRealScaled) - (wImagWide * bImagScaled);
		productImag = (wRealWide * bImagScaled) + (wImagWide * bRealScaled);

		// Sum and difference
		upperReal = aReal + productReal;
		upperImag = aImag + productImag;
		lowerReal = aReal - productReal;
		lowerImag = aImag - productImag;
	end

endmodule

`default_nettype wire

//--- hw/fftEngine.sv
/*
 * Iterative in-place FFT engine
 * Takes a bit-reversed frame when idle, runs all stages one butterfly per
 * cycle through a single butterflyUnit, then registers the real parts
 * of the spectrum with a one-cycle valid
 */

`timescale 1ns/1ps
`default_nettype none

module fftEngine import fftPkg::*, fftTablesPkg::*; (
	input logic advanceSignal,
	input logic reset,

	// Frame handshake
	input data_t frame [pointCount],
	input logic framePending,
	output logic frameTaken,

	// Result
	output data_t spectrumReal [pointCount],
	output logic outputValid
);

	engineState_t state;

	// Sequencing counters
	stageIndex_t stage;
	butterflyIndex_t butterfly;
	logic lastButterfly;
	logic lastStage;
	logic stepActive;

	// In-place working buffers
	data_t realBuf [pointCount];
	data_t imagBuf [pointCount];
	data_t nextReal [pointCount];
	data_t nextImag [pointCount];

	// Butterfly addressing
	pointIndex_t half;
	pointIndex_t offset;
	pointIndex_t aIndex;
	pointIndex_t bIndex;
	twiddleIndex_t twiddleIndex;

	// Butterfly results
	data_t upperReal;
	data_t upperImag;
	data_t lowerReal;
	data_t lowerImag;

	// Handshake and status
	assign frameTaken = (state == idle) && framePending;
	assign outputValid = (state == publish);
	assign stepActive = (state == load) || (state == compute);

	assign lastButterfly = (butterfly == butterflyIndex_t'(butterflyCount - 1));
	assign lastStage = (stage == stageIndex_t'(stageCount - 1));

	// Index generation
	always_comb begin
		half = pointIndex_t'(1) << stage;
		// Position inside the current group
		offset = pointIndex_t'(butterfly) & (half - pointIndex_t'(1));
		// Group base is (b div half) * 2 * half
		aIndex = ((pointIndex_t'(butterfly) >> stage) << (stage + 1)) | offset;
		bIndex = aIndex + half;
		// k = offset * N / (2 * half)
		twiddleIndex = twiddleIndex_t'(offset << (stageCount - 1 - stage));
	end

	butterflyUnit i_butterfly (
		.aReal(realBuf[aIndex]),
		.aImag(imagBuf[aIndex]),
		.bReal(realBuf[bIndex]),
		.bImag(imagBuf[bIndex]),
		.wReal(twiddleReal[twiddleIndex]),
		.wImag(twiddleImag[twiddleIndex]),
		.upperReal(upperReal),
		.upperImag(upperImag),
		.lowerReal(lowerReal),
		.lowerImag(lowerImag)
	);

	// Buffer contents after this cycle's butterfly
	always_comb begin
		nextReal = realBuf;
		nextImag = imagBuf;
		nextReal[aIndex] = upperReal;
		nextImag[aIndex] = upperImag;
		nextReal[bIndex] = lowerReal;
		nextImag[bIndex] = lowerImag;
	end

	// Working buffers
	always_ff @(posedge advanceSignal) begin
		if (frameTaken) begin
			// Real input only
			realBuf <= frame;
			imagBuf <= '{default: '0};
		end else if (stepActive) begin
			realBuf <= nextReal;
			imagBuf <= nextImag;
		end
	end

	// Sequencer
	always_ff @(posedge advanceSignal) begin
		if (reset) begin
			state <= idle;
			stage <= '0;
			butterfly <= '0;
			spectrumReal <= '{default: '0};
		end else begin
			case (state)
				idle: begin
					if (frameTaken) begin
						state <= load;
					end
				end
				// Fresh frame in the buffers, stage 0 butterfly 0 runs here
				load, compute: begin
					state <= compute;
					butterfly <= butterfly + 1'b1;
					if (lastButterfly) begin
						stage <= stage + 1'b1;
						if (lastStage) begin
							stage <= '0;
							state <= publish;
							// Includes the final butterfly of this cycle
							spectrumReal <= nextReal;
						end
					end
				end
				// outputValid cycle
				publish: state <= idle;
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/fftTop.sv
/*
 * Sliding-window FFT top
 * Sample window feeding the iterative butterfly engine
 */

`timescale 1ns/1ps
`default_nettype none

module fftTop import fftPkg::*; (
	input logic advanceSignal,
	input logic reset,

	// Audio input
	input sample_t sample,
	input logic sampleValid,

	// Spectrum output
	output data_t spectrumReal [pointCount],
	output logic outputValid
);

	// Window to engine
	data_t frame [pointCount];
	logic framePending;
	logic frameTaken;

	sampleWindow i_window (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.frameTaken(frameTaken),
		.framePending(framePending),
		.frame(frame)
	);

	fftEngine i_engine (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.frame(frame),
		.framePending(framePending),
		.frameTaken(frameTaken),
		.spectrumReal(spectrumReal),
		.outputValid(outputValid)
	);

endmodule

`default_nettype wire

//--- bench/fftChecker.sv
/*
 * FFT checker for the bench
 * Keeps its own sample window and pending flag, predicts every spectrum
 * with a reference FFT and compares each outputValid pulse against it
 */

`timescale 1ns/1ps
`default_nettype none

module fftChecker import fftPkg::*, fftTablesPkg::*; (
	input logic advanceSignal,
	input logic reset,

	// Observed DUT signals
	input sample_t sample,
	input logic sampleValid,
	input data_t spectrumReal [pointCount],
	input logic outputValid,

	// End of run handshake with the bench
	input logic endOfRun,
	output logic checkDone,
	output int valueErrors,
	output int protocolErrors
);

	// Model window with entry 0 newest
	sample_t modelWindow [pointCount];
	logic modelPending;
	engineState_t modelState;
	int butterfliesLeft;
	logic frameCopy;

	// Expected spectra
	data_t expectedReal [pointCount];
	data_t finalReal [pointCount];

	int sampleCount;
	int pulseCount;

	function automatic int reverseBits(input int index);
		int reversed;
		reversed = 0;
		for (int k = 0; k < stageCount; k++) begin
			if (index & (1 << k)) begin
				reversed = reversed | (1 << (stageCount - 1 - k));
			end
		end
		return reversed;
	endfunction

	// Reference FFT as a bit-reversed load then in-place radix-2 stages
	function automatic void referenceSpectrum(input sample_t window [pointCount],
			output data_t result [pointCount]);
		data_t re [pointCount];
		data_t im [pointCount];
		data_t wRe;
		data_t wIm;
		data_t bRe;
		data_t bIm;
		data_t prodRe;
		data_t prodIm;
		int half;
		int aIdx;
		int bIdx;
		int twiddle;
		for (int j = 0; j < pointCount; j++) begin
			// Integer sample moved above the fraction
			re[j] = data_t'(window[reverseBits(j)]) <<< fracBits;
			im[j] = '0;
		end
		for (int s = 0; s < stageCount; s++) begin
			half = 1 << s;
			for (int b = 0; b < pointCount / 2; b++) begin
				aIdx = (b / half) * 2 * half + (b % half);
				bIdx = aIdx + half;
				twiddle = (b % half) * pointCount / (2 * half);
				wRe = data_t'(twiddleReal[twiddle]);
				wIm = data_t'(twiddleImag[twiddle]);
				// b loses its fraction before the multiply
				bRe = re[bIdx] >>> fracBits;
				bIm = im[bIdx] >>> fracBits;
				// Wraps at dataWidth
				prodRe = wRe * bRe - wIm * bIm;
				prodIm = wRe * bIm + wIm * bRe;
				re[bIdx] = re[aIdx] - prodRe;
				im[bIdx] = im[aIdx] - prodIm;
				re[aIdx] = re[aIdx] + prodRe;
				im[aIdx] = im[aIdx] + prodIm;
			end
		end
		result = re;
	endfunction

	task automatic compareSpectrum(input data_t expected [pointCount]);
		for (int i = 0; i < pointCount; i++) begin
			if (spectrumReal[i] !== expected[i]) begin
				valueErrors++;
				$display("CHECK FAILED at %0t ns: spectrumReal[%0d] expected %0d, got %0d",
					$time, i, expected[i], spectrumReal[i]);
			end
		end
	endtask

	// Everything read here is as it stood before the edge
	always @(posedge advanceSignal) begin
		if (reset) begin
			modelWindow = '{default: '0};
			modelPending = 1'b0;
			modelState = idle;
			butterfliesLeft = 0;
			expectedReal = '{default: '0};
			sampleCount = 0;
			pulseCount = 0;
			valueErrors = 0;
			protocolErrors = 0;
			checkDone = 1'b0;
		end else begin
			// Every pulse seen counts, due or not
			if (outputValid === 1'b1) begin
				pulseCount++;
			end

			// Pulse exactly in the model's publish cycle
			if (outputValid !== (modelState == publish)) begin
				protocolErrors++;
				if (modelState == publish) begin
					$display("At %0t ns the expected outputValid pulse is missing", $time);
				end else begin
					$display("At %0t ns outputValid pulsed when no spectrum was due", $time);
				end
			end else if (outputValid) begin
				compareSpectrum(expectedReal);
			end else if (sampleCount == 0) begin
				// Nothing published yet so still zero
				compareSpectrum(expectedReal);
			end

			if (endOfRun && !checkDone) begin
				if (pulseCount > sampleCount) begin
					protocolErrors++;
					$display("Saw %0d spectra for only %0d samples", pulseCount, sampleCount);
				end
				if (modelState != idle || modelPending) begin
					protocolErrors++;
					$display("The engine was still busy when the run ended");
				end
				// Last frame has to hold the newest window
				referenceSpectrum(modelWindow, finalReal);
				compareSpectrum(finalReal);
				checkDone = 1'b1;
			end

			// Engine model
			frameCopy = (modelState == idle) && modelPending;
			case (modelState)
				idle: begin
					if (frameCopy) begin
						referenceSpectrum(modelWindow, expectedReal);
						modelState = load;
					end
				end
				load: begin
					// First butterfly runs on this edge
					modelState = compute;
					butterfliesLeft = stageCount * pointCount / 2 - 1;
				end
				compute: begin
					if (butterfliesLeft == 1) begin
						modelState = publish;
					end else begin
						butterfliesLeft--;
					end
				end
				default: modelState = idle;
			endcase

			// New sample beats the frame copy
			if (sampleValid) begin
				modelPending = 1'b1;
				sampleCount++;
				for (int i = pointCount - 1; i > 0; i--) begin
					modelWindow[i] = modelWindow[i-1];
				end
				modelWindow[0] = sample;
			end else if (frameCopy) begin
				modelPending = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- bench/fftTb.sv
/*
 * Sliding-window FFT testbench
 * Clock, reset, impulse, random, full-scale and burst stimulus for
 * fftTop, with fftChecker comparing and a watchdog bounding the run
 */

`timescale 1ns/1ps
`default_nettype none

module fftTb import fftPkg::*; ();

	localparam int clockPeriod = 100;
	localparam int resetCycles = 5;
	localparam int spacing = 20;
	localparam int impulseSamples = 9;
	localparam int spacedSamples = 24;
	// Per sign
	localparam int constantSamples = 8;
	localparam int burstSamples = 40;
	localparam int totalSamples =
		impulseSamples + spacedSamples + 2 * constantSamples + burstSamples;
	// One spacing period per sample, margin for reset, idle and drain
	localparam int watchdogCycles = totalSamples * spacing + 200;

	logic advanceSignal;
	logic reset;
	sample_t sample;
	logic sampleValid;
	data_t spectrumReal [pointCount];
	logic outputValid;

	logic endOfRun;
	logic checkDone;
	int valueErrors;
	int protocolErrors;

	logic [31:0] lfsrState;
	sample_t randomValue;
	int quietCycles;

	always #(clockPeriod / 2) advanceSignal = ~advanceSignal;

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] state);
		logic [31:0] stepped;
		stepped = state >> 1;
		if (state[0]) begin
			stepped = stepped ^ 32'h8020_0003;
		end
		return stepped;
	endfunction

	// One step per sample bit
	task automatic drawSample(output sample_t value);
		for (int i = 0; i < sampleWidth; i++) begin
			value[i] = lfsrState[0];
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// Entered on a falling edge, sampleValid high for one cycle
	task automatic presentSample(input sample_t value, input int idleCycles);
		sample = value;
		sampleValid = 1'b1;
		@(negedge advanceSignal);
		sampleValid = 1'b0;
		repeat (idleCycles) @(negedge advanceSignal);
	endtask

	// Quiet for longer than the gap between two merged frames
	task automatic waitForQuiet();
		quietCycles = 0;
		while (quietCycles < spacing) begin
			@(negedge advanceSignal);
			if (outputValid) begin
				quietCycles = 0;
			end else begin
				quietCycles++;
			end
		end
	endtask

	fftTop i_dut (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.spectrumReal(spectrumReal),
		.outputValid(outputValid)
	);

	fftChecker i_checker (
		.advanceSignal(advanceSignal),
		.reset(reset),
		.sample(sample),
		.sampleValid(sampleValid),
		.spectrumReal(spectrumReal),
		.outputValid(outputValid),
		.endOfRun(endOfRun),
		.checkDone(checkDone),
		.valueErrors(valueErrors),
		.protocolErrors(protocolErrors)
	);

	initial begin
		advanceSignal = 1'b0;
		reset = 1'b1;
		sample = '0;
		sampleValid = 1'b0;
		endOfRun = 1'b0;
		lfsrState = 32'hb0e0_9f49;
		repeat (resetCycles) @(posedge advanceSignal);
		@(negedge advanceSignal);
		reset = 1'b0;

		// Idle after reset, spectrum must stay zero
		repeat (spacing) @(negedge advanceSignal);

		// Impulse walking through the window
		presentSample(sample_t'(1000), spacing - 1);
		for (int i = 1; i < impulseSamples; i++) begin
			presentSample('0, spacing - 1);
		end

		// One frame per sample
		for (int i = 0; i < spacedSamples; i++) begin
			drawSample(randomValue);
			presentSample(randomValue, spacing - 1);
		end

		// Full scale both signs
		for (int i = 0; i < constantSamples; i++) begin
			presentSample(sample_t'(2047), spacing - 1);
		end
		for (int i = 0; i < constantSamples; i++) begin
			presentSample(sample_t'(-2048), spacing - 1);
		end

		// Back to back, frames merge while the engine is busy
		for (int i = 0; i < burstSamples; i++) begin
			drawSample(randomValue);
			presentSample(randomValue, 0);
		end
		waitForQuiet();

		endOfRun = 1'b1;
		wait (checkDone === 1'b1);
		$display("Errors: %0d value mismatches, %0d protocol errors",
			valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired after %0d cycles before the run completed",
			watchdogCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
hw/fftPkg.sv
hw/fftTablesPkg.sv
hw/sampleWindow.sv
hw/butterflyUnit.sv
hw/fftEngine.sv
hw/fftTop.sv
bench/fftChecker.sv
bench/fftTb.sv

//--- run.sh
#!/bin/sh
# Build and run the sliding-window FFT testbench with Verilator
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module fftTb -f flist.f -o fftSim \
	&& ./obj_dir/fftSim | tee sim.log \
	&& grep -qx 'Simulation passed' sim.log \
	&& echo "Run passed" \
	|| { echo "Run did not pass, see sim.log"; exit 1; }
